// ==== cnn_pkg.sv ====
package cnn_pkg;

    // serial timing
    localparam int CLKS_PER_BIT = 8;

    // layer sizes
    localparam int FEAT_LEN    = 16;
    localparam int NUM_CLASSES = 10;
    localparam int NUM_FILES   = 12;
    localparam int BIAS_FILE   = 11;
    localparam int ACC_W       = 20;

    typedef logic [7:0]  byte_t;
    typedef logic [15:0] file_idx_t;
    typedef logic [3:0]  class_t;

    // request header, ascii R
    localparam byte_t CMD_READ = 8'h52;

    typedef struct packed {
        logic  tx_en;
        byte_t tx_data;
    } ser_tx_t;

    typedef struct packed {
        logic  rx_rdy;
        byte_t rx_data;
    } ser_rx_t;

    // one payload byte on its way into storage
    typedef struct packed {
        logic       we;
        file_idx_t  file;
        logic [7:0] offset;
        byte_t      data;
    } load_wr_t;

    // payload bytes carried by a file
    function automatic logic [7:0] file_len(input file_idx_t idx);
        if (idx == file_idx_t'(BIAS_FILE)) begin
            return 8'(NUM_CLASSES);
        end
        return 8'(FEAT_LEN);
    endfunction

endpackage

// ==== dense_classifier.sv ====
`timescale 1ns/1ps

module dense_classifier (
    input  logic              clk,
    input  logic              reset,
    input  cnn_pkg::load_wr_t wr,
    input  logic              calc_start,
    output cnn_pkg::class_t   answer,
    output logic              number_valid
);
    import cnn_pkg::*;

    localparam int IDX_W = $clog2(FEAT_LEN);
    localparam logic [IDX_W-1:0]       K_LAST   = IDX_W'(FEAT_LEN - 1);
    localparam class_t                 CLS_LAST = class_t'(NUM_CLASSES - 1);
    localparam logic signed [ACC_W-1:0] ACC_MIN = {1'b1, {(ACC_W - 1){1'b0}}};

    typedef enum logic [1:0] {C_IDLE, C_MAC, C_CMP, C_DONE} calc_state_t;

    byte_t feat   [FEAT_LEN];
    byte_t weight [NUM_CLASSES][FEAT_LEN];
    byte_t bias   [NUM_CLASSES];

    calc_state_t             state;
    logic [IDX_W-1:0]        k;
    class_t                  cls;
    class_t                  row;
    logic signed [15:0]      prod;
    logic signed [ACC_W-1:0] acc;
    logic signed [ACC_W-1:0] score;
    logic signed [ACC_W-1:0] max_score;

    // files 1..10 map to weight rows 0..9
    assign row = class_t'(wr.file - 16'd1);

    always_ff @(posedge clk) begin
        if (wr.we) begin
            if (wr.file == '0) begin
                feat[wr.offset[IDX_W-1:0]] <= wr.data;
            end else if (wr.file == file_idx_t'(BIAS_FILE)) begin
                bias[wr.offset[3:0]] <= wr.data;
            end else begin
                weight[row][wr.offset[IDX_W-1:0]] <= wr.data;
            end
        end
    end

    assign prod  = $signed(feat[k]) * $signed(weight[cls][k]);
    assign score = acc + ACC_W'($signed(bias[cls]));

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state        <= C_IDLE;
            k            <= '0;
            cls          <= '0;
            acc          <= '0;
            max_score    <= ACC_MIN;
            answer       <= '0;
            number_valid <= 1'b0;
        end else begin
            case (state)
                C_IDLE: begin
                    if (calc_start) begin
                        k         <= '0;
                        cls       <= '0;
                        acc       <= '0;
                        max_score <= ACC_MIN;
                        state     <= C_MAC;
                    end
                end
                // one product per cycle, k wraps back to 0
                C_MAC: begin
                    acc <= acc + ACC_W'(prod);
                    k   <= k + 1'b1;
                    if (k == K_LAST) begin
                        state <= C_CMP;
                    end
                end
                C_CMP: begin
                    // strict compare so ties keep the lower class
                    if (score > max_score) begin
                        max_score <= score;
                        answer    <= cls;
                    end
                    acc <= '0;
                    if (cls == CLS_LAST) begin
                        number_valid <= 1'b1;
                        state        <= C_DONE;
                    end else begin
                        cls   <= cls + 1'b1;
                        state <= C_MAC;
                    end
                end
                // result held until reset
                C_DONE:  state <= C_DONE;
                default: state <= C_IDLE;
            endcase
        end
    end

endmodule

// ==== digit_assertions.sv ====
`timescale 1ns/1ps

module digit_assertions (
    input logic            clk,
    input logic            reset,
    input logic            tx,
    input logic            tx_busy,
    input logic            number_valid,
    input cnn_pkg::class_t answer
);
    import cnn_pkg::*;

    int fail_count;

    initial fail_count = 0;

    // idle line stays at the stop level
    tx_idle_high: assert property (@(posedge clk) disable iff (reset) !tx_busy |-> tx)
        else begin
            fail_count++;
            $error("tx low while the serial link is idle");
        end

    valid_held: assert property (@(posedge clk) disable iff (reset) !$fell(number_valid))
        else begin
            fail_count++;
            $error("number_valid fell without reset");
        end

    answer_range: assert property (@(posedge clk) disable iff (reset)
        number_valid |-> (answer < class_t'(NUM_CLASSES)))
        else begin
            fail_count++;
            $error("answer out of class range");
        end

endmodule

bind digit_top digit_assertions u_assertions (
    .clk          (clk),
    .reset        (reset),
    .tx           (tx),
    .tx_busy      (tx_busy),
    .number_valid (number_valid),
    .answer       (answer)
);

// ==== digit_top.sv ====
`timescale 1ns/1ps

module digit_top (
    input  logic            clk,
    input  logic            reset,
    input  logic            rx,
    output logic            tx,
    output cnn_pkg::class_t answer,
    output logic            number_valid
);
    import cnn_pkg::*;

    typedef enum logic [1:0] {SEQ_LOAD, SEQ_WAIT, SEQ_CALC, SEQ_END} seq_state_t;

    seq_state_t seq_state;
    file_idx_t  cur_file;
    ser_tx_t    tx_req;
    logic       tx_busy;
    ser_rx_t    rx_byte;
    load_wr_t   wr;
    logic       load_start;
    logic       load_done;
    logic       calc_start;

    uart_link u_uart (
        .clk     (clk),
        .reset   (reset),
        .rx      (rx),
        .tx      (tx),
        .tx_req  (tx_req),
        .tx_busy (tx_busy),
        .rx_out  (rx_byte)
    );

    file_loader u_loader (
        .clk        (clk),
        .reset      (reset),
        .load_start (load_start),
        .load_file  (cur_file),
        .load_done  (load_done),
        .tx_req     (tx_req),
        .tx_busy    (tx_busy),
        .rx_in      (rx_byte),
        .wr         (wr)
    );

    dense_classifier u_dense (
        .clk          (clk),
        .reset        (reset),
        .wr           (wr),
        .calc_start   (calc_start),
        .answer       (answer),
        .number_valid (number_valid)
    );

    // loader is back in idle the cycle after load_done
    assign load_start = (seq_state == SEQ_LOAD);
    assign calc_start = (seq_state == SEQ_CALC);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            seq_state <= SEQ_LOAD;
            cur_file  <= '0;
        end else begin
            case (seq_state)
                SEQ_LOAD: seq_state <= SEQ_WAIT;
                SEQ_WAIT: begin
                    if (load_done) begin
                        if (cur_file == file_idx_t'(NUM_FILES - 1)) begin
                            seq_state <= SEQ_CALC;
                        end else begin
                            cur_file  <= cur_file + 16'd1;
                            seq_state <= SEQ_LOAD;
                        end
                    end
                end
                SEQ_CALC: seq_state <= SEQ_END;
                default:  seq_state <= SEQ_END;
            endcase
        end
    end

endmodule

// ==== file_loader.sv ====
`timescale 1ns/1ps

module file_loader (
    input  logic               clk,
    input  logic               reset,
    input  logic               load_start,
    input  cnn_pkg::file_idx_t load_file,
    output logic               load_done,
    output cnn_pkg::ser_tx_t   tx_req,
    input  logic               tx_busy,
    input  cnn_pkg::ser_rx_t   rx_in,
    output cnn_pkg::load_wr_t  wr
);
    import cnn_pkg::*;

    typedef enum logic [2:0] {
        L_IDLE,
        L_HEAD,
        L_IDX_LO,
        L_IDX_HI,
        L_RECV,
        L_DONE
    } load_state_t;

    load_state_t state;
    file_idx_t   file_q;
    logic [7:0]  byte_cnt;
    logic [7:0]  last_cnt;
    logic        rx_take;

    assign last_cnt  = file_len(file_q) - 8'd1;
    assign rx_take   = (state == L_RECV) && rx_in.rx_rdy;
    assign load_done = (state == L_DONE);

    // request bytes, held until the link takes them
    always_comb begin
        tx_req = '0;
        case (state)
            L_HEAD: begin
                tx_req.tx_en   = 1'b1;
                tx_req.tx_data = CMD_READ;
            end
            L_IDX_LO: begin
                tx_req.tx_en   = 1'b1;
                tx_req.tx_data = file_q[7:0];
            end
            L_IDX_HI: begin
                tx_req.tx_en   = 1'b1;
                tx_req.tx_data = file_q[15:8];
            end
            default: tx_req = '0;
        endcase
    end

    always_comb begin
        wr.we     = rx_take;
        wr.file   = file_q;
        wr.offset = byte_cnt;
        wr.data   = rx_in.rx_data;
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state    <= L_IDLE;
            file_q   <= '0;
            byte_cnt <= '0;
        end else begin
            case (state)
                L_IDLE: begin
                    if (load_start) begin
                        file_q   <= load_file;
                        byte_cnt <= '0;
                        state    <= L_HEAD;
                    end
                end
                // busy goes high the edge after a byte is taken
                L_HEAD:   if (!tx_busy) state <= L_IDX_LO;
                L_IDX_LO: if (!tx_busy) state <= L_IDX_HI;
                L_IDX_HI: if (!tx_busy) state <= L_RECV;
                L_RECV: begin
                    if (rx_take) begin
                        byte_cnt <= byte_cnt + 8'd1;
                        if (byte_cnt == last_cnt) begin
                            state <= L_DONE;
                        end
                    end
                end
                L_DONE:  state <= L_IDLE;
                default: state <= L_IDLE;
            endcase
        end
    end

endmodule

// ==== list.f ====
cnn_pkg.sv
uart_link.sv
file_loader.sv
dense_classifier.sv
digit_top.sv
digit_assertions.sv
tb_host_model.sv
tb_digit_top.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the testbench with verilator, then decide from the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f list.f --top-module tb_digit_top \
    -o sim_digit || { echo "build failed"; exit 1; }
./obj_dir/sim_digit 2>&1 | tee sim.log
grep -q "All tests passed" sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }

// ==== tb_digit_top.sv ====
`timescale 1ns/1ps

module tb_digit_top;
    import cnn_pkg::*;

    localparam int NUM_TESTS   = 7;
    localparam int HOLD_CLKS   = 16;
    localparam int WATCHDOG_NS = NUM_TESTS * NUM_FILES * 20 * 10 * CLKS_PER_BIT * 4 * 2;

    logic   clk;
    logic   reset;
    logic   rx;
    logic   tx;
    class_t answer;
    logic   number_valid;
    logic [NUM_FILES-1:0][FEAT_LEN-1:0][7:0] files;
    int          served;
    int          host_errors;
    logic [31:0] rng_state;
    int          check_errors;
    int          pass_count;
    int          fail_count;

    digit_top u_dut (
        .clk          (clk),
        .reset        (reset),
        .rx           (rx),
        .tx           (tx),
        .answer       (answer),
        .number_valid (number_valid)
    );

    tb_host_model u_host (
        .clk     (clk),
        .reset   (reset),
        .tx_line (tx),
        .rx_line (rx),
        .files   (files),
        .served  (served),
        .errors  (host_errors)
    );

    always #2 clk = ~clk;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic byte_t next_byte();
        rng_state = xorshift(rng_state);
        return rng_state[7:0];
    endfunction

    // mode 0 random, 1 zero weights with equal biases, 2 tie at 3 and 7, 3 all negative
    task automatic fill_files(input int mode);
        for (int f = 0; f < NUM_FILES; f++) begin
            for (int i = 0; i < FEAT_LEN; i++) begin
                if (mode == 0) begin
                    files[f][i] = next_byte();
                end else if (mode == 3) begin
                    files[f][i] = (f == 0) ? ((next_byte() & 8'h7f) | 8'h01)
                                           : (next_byte() | 8'h80);
                end else if (f == 0) begin
                    files[f][i] = next_byte();
                end else if (f == BIAS_FILE) begin
                    files[f][i] = (mode == 1) ? 8'h15 : (next_byte() & 8'h3f);
                end else begin
                    files[f][i] = 8'h00;
                end
            end
        end
        if (mode == 2) begin
            files[BIAS_FILE][3] = 8'h70;
            files[BIAS_FILE][7] = 8'h70;
        end
        if (mode == 3) begin
            // class 0 scores lowest, so the answer has to move off its reset value
            for (int i = 0; i < FEAT_LEN; i++) begin
                files[1][i] = 8'h80;
            end
            files[BIAS_FILE][0] = 8'h80;
        end
    endtask

    // signed dot product plus bias, strict compare from the most negative score
    function automatic class_t model_answer();
        int     score;
        int     best;
        class_t best_cls;
        best     = -(1 << (ACC_W - 1));
        best_cls = '0;
        for (int c = 0; c < NUM_CLASSES; c++) begin
            score = int'($signed(files[BIAS_FILE][c]));
            for (int k = 0; k < FEAT_LEN; k++) begin
                score += int'($signed(files[0][k])) * int'($signed(files[c + 1][k]));
            end
            if (score > best) begin
                best     = score;
                best_cls = class_t'(c);
            end
        end
        return best_cls;
    endfunction

    task automatic run_test(input string name, input int mode);
        class_t expected;
        class_t held;
        int     errs_before;
        int     host_before;
        @(negedge clk);
        reset = 1'b1;
        fill_files(mode);
        expected    = (mode == 1) ? 4'd0 : (mode == 2) ? 4'd3 : model_answer();
        errs_before = check_errors;
        host_before = host_errors;
        repeat (5) begin
            @(negedge clk);
            assert (tx == 1'b1 && number_valid == 1'b0) else begin
                check_errors++;
                $display("%s: tx or number_valid not idle during reset", name);
            end
        end
        reset = 1'b0;
        while (number_valid !== 1'b1) begin
            @(negedge clk);
            assert (!(number_valid && served < NUM_FILES)) else begin
                check_errors++;
                $display("%s: number_valid rose before the last file was served", name);
            end
        end
        assert (answer == expected) else begin
            check_errors++;
            $display("[FAIL] %s: expected %0d, actual %0d", name, expected, answer);
        end
        assert (served == NUM_FILES) else begin
            check_errors++;
            $display("[FAIL] %s files served: expected %0d, actual %0d", name, NUM_FILES, served);
        end
        held = answer;
        repeat (HOLD_CLKS) begin
            @(negedge clk);
            assert (number_valid && answer == held) else begin
                check_errors++;
                $display("%s: result did not hold after number_valid", name);
            end
        end
        assert (host_errors == host_before) else begin
            check_errors++;
            $display("%s: the host saw a bad request stream", name);
        end
        if (check_errors == errs_before) begin
            pass_count++;
            $display("test %s: ok", name);
        end else begin
            fail_count++;
            $display("test %s: failed", name);
        end
    endtask

    initial begin
        clk          = 1'b0;
        reset        = 1'b1;
        files        = '0;
        rng_state    = 32'hced4;
        check_errors = 0;
        pass_count   = 0;
        fail_count   = 0;
        for (int t = 0; t < 4; t++) begin
            run_test($sformatf("random_%0d", t), 0);
        end
        run_test("tie_zero_weights", 1);
        run_test("tie_classes_3_7", 2);
        run_test("all_negative", 3);
        if (u_dut.u_assertions.fail_count != 0) begin
            $display("bound assertions failed %0d times", u_dut.u_assertions.fail_count);
        end
        $display("%0d tests, %0d passed, %0d failed", NUM_TESTS, pass_count, fail_count);
        if (fail_count == 0 && u_dut.u_assertions.fail_count == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: no result after %0d ns", WATCHDOG_NS);
        $display("Some tests failed");
        $finish;
    end

endmodule

// ==== tb_host_model.sv ====
`timescale 1ns/1ps

module tb_host_model (
    input  logic clk,
    input  logic reset,
    input  logic tx_line,
    output logic rx_line,
    input  logic [cnn_pkg::NUM_FILES-1:0][cnn_pkg::FEAT_LEN-1:0][7:0] files,
    output int   served,
    output int   errors
);
    import cnn_pkg::*;

    task automatic wait_clks(input int n);
        repeat (n) @(negedge clk);
    endtask

    task automatic wait_start();
        while (tx_line !== 1'b0) begin
            @(negedge clk);
        end
    endtask

    // entered at the first clock that shows the start bit, returns at mid stop bit
    task automatic read_byte(output byte_t b);
        wait_clks(CLKS_PER_BIT / 2);
        assert (tx_line == 1'b0) else begin
            errors++;
            $display("request start bit ended early");
        end
        for (int i = 0; i < 8; i++) begin
            wait_clks(CLKS_PER_BIT);
            b[i] = tx_line;
        end
        wait_clks(CLKS_PER_BIT);
        assert (tx_line == 1'b1) else begin
            errors++;
            $display("request stop bit missing");
        end
    endtask

    task automatic send_byte(input byte_t b);
        rx_line = 1'b0;
        wait_clks(CLKS_PER_BIT);
        for (int i = 0; i < 8; i++) begin
            rx_line = b[i];
            wait_clks(CLKS_PER_BIT);
        end
        rx_line = 1'b1;
        wait_clks(CLKS_PER_BIT);
    endtask

    task automatic serve_request();
        byte_t hdr;
        byte_t lo;
        byte_t hi;
        int    len;
        read_byte(hdr);
        wait_start();
        read_byte(lo);
        wait_start();
        read_byte(hi);
        assert (hdr == CMD_READ) else begin
            errors++;
            $display("[FAIL] file %0d header: expected %h, actual %h", served, CMD_READ, hdr);
        end
        assert ({hi, lo} == 16'(served)) else begin
            errors++;
            $display("[FAIL] request index: expected %0d, actual %0d", served, {hi, lo});
        end
        // finish the stop bit before answering
        wait_clks(CLKS_PER_BIT / 2);
        if (served < NUM_FILES) begin
            len = (served == BIAS_FILE) ? NUM_CLASSES : FEAT_LEN;
            for (int i = 0; i < len; i++) begin
                send_byte(files[served][i]);
            end
            served++;
        end else begin
            errors++;
            $display("request after all %0d files were served", NUM_FILES);
        end
    endtask

    initial begin
        rx_line = 1'b1;
        served  = 0;
        errors  = 0;
        forever begin
            @(negedge clk);
            if (reset) begin
                served = 0;
            end else if (tx_line == 1'b0) begin
                serve_request();
            end
        end
    end

endmodule

// ==== uart_link.sv ====
`timescale 1ns/1ps

module uart_link (
    input  logic             clk,
    input  logic             reset,
    input  logic             rx,
    output logic             tx,
    input  cnn_pkg::ser_tx_t tx_req,
    output logic             tx_busy,
    output cnn_pkg::ser_rx_t rx_out
);
    import cnn_pkg::*;

    localparam int CNT_W = $clog2(CLKS_PER_BIT);
    localparam logic [CNT_W-1:0] BIT_END  = CNT_W'(CLKS_PER_BIT - 1);
    localparam logic [CNT_W-1:0] HALF_END = CNT_W'(CLKS_PER_BIT / 2 - 1);

    typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_t;

    logic [9:0]       tx_shift;
    logic [3:0]       tx_bits;
    logic [CNT_W-1:0] tx_cnt;

    logic             rx_meta;
    logic             rx_s;
    logic             rx_prev;
    rx_state_t        rx_state;
    logic [CNT_W-1:0] rx_cnt;
    logic [2:0]       rx_bits;
    byte_t            rx_shift;

    // line idles high since the shifter refills with ones
    assign tx = tx_shift[0];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            tx_shift <= '1;
            tx_bits  <= '0;
            tx_cnt   <= '0;
            tx_busy  <= 1'b0;
        end else if (!tx_busy) begin
            if (tx_req.tx_en) begin
                // stop bit, data lsb first, start bit
                tx_shift <= {1'b1, tx_req.tx_data, 1'b0};
                tx_bits  <= '0;
                tx_cnt   <= '0;
                tx_busy  <= 1'b1;
            end
        end else if (tx_cnt == BIT_END) begin
            tx_cnt   <= '0;
            tx_shift <= {1'b1, tx_shift[9:1]};
            tx_bits  <= tx_bits + 4'd1;
            if (tx_bits == 4'd9) begin
                tx_busy <= 1'b0;
            end
        end else begin
            tx_cnt <= tx_cnt + 1'b1;
        end
    end

    // two-flop sync plus one stage for edge detect
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            rx_meta <= 1'b1;
            rx_s    <= 1'b1;
            rx_prev <= 1'b1;
        end else begin
            rx_meta <= rx;
            rx_s    <= rx_meta;
            rx_prev <= rx_s;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            rx_state <= RX_IDLE;
            rx_cnt   <= '0;
            rx_bits  <= '0;
            rx_shift <= '0;
            rx_out   <= '0;
        end else begin
            rx_out.rx_rdy <= 1'b0;
            case (rx_state)
                RX_IDLE: begin
                    if (rx_prev && !rx_s) begin
                        rx_cnt   <= '0;
                        rx_state <= RX_START;
                    end
                end
                RX_START: begin
                    if (rx_cnt == HALF_END) begin
                        rx_cnt   <= '0;
                        rx_bits  <= '0;
                        // glitch, not a real start bit
                        rx_state <= rx_s ? RX_IDLE : RX_DATA;
                    end else begin
                        rx_cnt <= rx_cnt + 1'b1;
                    end
                end
                RX_DATA: begin
                    if (rx_cnt == BIT_END) begin
                        rx_cnt   <= '0;
                        rx_shift <= {rx_s, rx_shift[7:1]};
                        rx_bits  <= rx_bits + 3'd1;
                        if (rx_bits == 3'd7) begin
                            rx_state <= RX_STOP;
                        end
                    end else begin
                        rx_cnt <= rx_cnt + 1'b1;
                    end
                end
                RX_STOP: begin
                    if (rx_cnt == BIT_END) begin
                        rx_cnt         <= '0;
                        rx_out.rx_rdy  <= rx_s;
                        rx_out.rx_data <= rx_shift;
                        rx_state       <= RX_IDLE;
                    end else begin
                        rx_cnt <= rx_cnt + 1'b1;
                    end
                end
                default: rx_state <= RX_IDLE;
            endcase
        end
    end

endmodule
